/* compile.f */
rtl/plic_cfg_pkg.sv
rtl/plic_bus_pkg.sv
rtl/plic_wb_slave.sv
rtl/plic_gateway.sv
rtl/plic_arbiter.sv
rtl/plic_core.sv
rtl/plic_top.sv
test/plic_properties.sv
test/plic_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module plic_tb -f compile.f
out=$(./obj_dir/Vplic_tb 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

/* test/plic_tb.sv */
`timescale 1ns/1ps

module plic_tb;
    import plic_cfg_pkg::*;
    import plic_bus_pkg::*;

    logic        clk;
    logic        rstn;
    wb_req_t     wb_in;
    wb_rsp_t     wb_out;
    src_vec_t    src_req;
    logic        irq;
    prio_t       m_prio [num_src]; // model of the controller.
    src_vec_t    m_enable;
    src_vec_t    m_pending;
    src_vec_t    m_inflight;
    prio_t       m_threshold;
    logic [31:0] lfsr_q;
    int          cycle_cnt = 0;

    plic_top dut0 (.clk(clk), .rstn(rstn), .wb_in(wb_in), .wb_out(wb_out),
                   .src_req(src_req), .irq(irq));

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == 4000)
        begin
            $display("timeout, the run did not finish within %0d cycles", cycle_cnt);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    // galois form, taps 32 22 2 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic src_id_t ref_claim();
        src_id_t best;
        prio_t   best_p;
        best   = '0;
        best_p = '0;
        for (int i = 1; i < num_src; i++)
        begin
            // strictly greater keeps the lower id on a tie.
            if (m_pending[i] && m_enable[i] && m_prio[i] > m_threshold && m_prio[i] > best_p)
            begin
                best   = src_id_t'(i);
                best_p = m_prio[i];
            end
        end
        return best;
    endfunction

    function automatic logic [31:0] ref_read(input logic [addr_w-1:0] adr);
        if (int'(adr) < 4 * num_src)
            return 32'(m_prio[int'(adr) / 4]);
        if (adr == pending_addr)
            return m_pending;
        if (adr == enable_addr)
            return m_enable;
        if (adr == threshold_addr)
            return 32'(m_threshold);
        return '0;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_id(input string name, input src_id_t exp, input src_id_t act);
        if (act !== exp)
        begin
            $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_irq();
        @(negedge clk);
        check_bit("irq", ref_claim() != '0, irq);
    endtask

    task automatic wb_access(input logic we, input logic [addr_w-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        @(posedge clk);
        wb_in <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do
            @(negedge clk);
        while (!wb_out.ack);
        rdat = wb_out.dat;
        @(posedge clk);
        wb_in <= '0;
    endtask

    task automatic wb_write(input logic [addr_w-1:0] adr, input logic [31:0] dat);
        logic [31:0] d;
        wb_access(1'b1, adr, dat, d);
        if (int'(adr) >= 4 && int'(adr) < 4 * num_src)
            m_prio[int'(adr) / 4] = dat[prio_w-1:0];
        else if (adr == enable_addr)
            m_enable = dat;
        else if (adr == threshold_addr)
            m_threshold = dat[prio_w-1:0];
        else if (adr == claim_addr && dat < num_src)
            m_inflight[dat[id_w-1:0]] = 1'b0; // gateway may forward again.
        check_irq();
    endtask

    task automatic read_check(input logic [addr_w-1:0] adr);
        logic [31:0] d;
        wb_access(1'b0, adr, '0, d);
        check_word($sformatf("rdata@%h", adr), ref_read(adr), d);
    endtask

    task automatic claim_check(output src_id_t id);
        logic [31:0] d;
        id = ref_claim();
        wb_access(1'b0, claim_addr, '0, d);
        check_id("claim", id, d[id_w-1:0]);
        check_word("claim upper", '0, 32'(d[31:id_w]));
        if (id != '0)
            m_pending[id] = 1'b0;
        check_irq();
    endtask

    // gateway forwards every high level that is not in flight.
    task automatic settle();
        repeat (4) @(posedge clk);
        m_pending  = m_pending | (src_req & ~m_inflight & ~src_vec_t'(1));
        m_inflight = m_inflight | (src_req & ~src_vec_t'(1));
        check_irq();
    endtask

    task automatic set_levels(input src_vec_t v);
        @(posedge clk);
        src_req <= v;
        settle();
    endtask

    task automatic drain();
        src_id_t id;
        set_levels('0);
        do
            claim_check(id);
        while (id != '0);
        for (int i = 1; i < num_src; i++)
            if (m_inflight[i])
                wb_write(claim_addr, 32'(i));
        settle();
        read_check(pending_addr);
    endtask

    initial
    begin
        src_id_t id;
        rstn        = 1'b0;
        wb_in       = '0;
        src_req     = '0;
        lfsr_q      = 32'ha1e6;
        m_enable    = '0;
        m_pending   = '0;
        m_inflight  = '0;
        m_threshold = '0;
        for (int i = 0; i < num_src; i++)
            m_prio[i] = '0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        check_irq();
        read_check(24'h000014);
        read_check(pending_addr);
        read_check(enable_addr);
        read_check(threshold_addr);
        claim_check(id);

        wb_write(24'h00000c, 32'hffff_fffd);
        wb_write(24'h00007c, 32'h2);
        wb_write(prio_base, 32'h7); // slot 0 has no register.
        wb_write(enable_addr, 32'h5a5a_a5a5);
        wb_write(threshold_addr, 32'h6);
        wb_write(pending_addr, 32'hffff_ffff);
        wb_write(24'h003000, 32'h1234_5678);
        read_check(24'h00000c);
        read_check(24'h00007c);
        read_check(prio_base);
        read_check(enable_addr);
        read_check(threshold_addr);
        read_check(pending_addr);
        read_check(24'h003000);
        read_check(24'h000080);

        wb_write(enable_addr, 32'hffff_fffe);
        wb_write(threshold_addr, 32'h0);
        wb_write(24'h00001c, 32'h7); // sources 7 and 18 tie.
        wb_write(24'h000048, 32'h7);
        wb_write(24'h000008, rand_bits(3));
        wb_write(24'h00002c, rand_bits(3));
        wb_write(24'h000064, rand_bits(3));
        set_levels(32'h0204_0884);
        read_check(pending_addr);
        claim_check(id);
        read_check(pending_addr);
        claim_check(id);
        settle(); // 7 still high but in flight.
        read_check(pending_addr);
        wb_write(claim_addr, 32'd7);
        settle();
        read_check(pending_addr);
        claim_check(id);
        drain();

        wb_write(24'h000014, 32'h3);
        wb_write(enable_addr, 32'h0);
        set_levels(32'h0000_0020);
        read_check(pending_addr);
        wb_write(enable_addr, 32'h0000_0020);
        wb_write(threshold_addr, 32'h3);
        wb_write(threshold_addr, 32'h4);
        wb_write(threshold_addr, 32'h2);
        drain();

        repeat (8)
        begin
            wb_write(enable_addr, rand_bits(32));
            wb_write(threshold_addr, rand_bits(3));
            repeat (8)
                wb_write(24'(rand_bits(5)) << 2, rand_bits(3));
            set_levels(rand_bits(32) & ~32'h1);
            read_check(pending_addr);
            repeat (12)
            begin
                claim_check(id);
                if (id != '0 && rand_bits(1) == 32'h1)
                begin
                    wb_write(claim_addr, 32'(id));
                    settle();
                end
            end
            for (int i = 1; i < num_src; i++)
                if (m_inflight[i])
                begin
                    wb_write(claim_addr, 32'(i));
                    settle(); // a level still high re-pends.
                end
            settle();
            read_check(pending_addr);
        end
        drain();

        $display("All checks passed");
        $finish;
    end

endmodule

/* test/plic_properties.sv */
`timescale 1ns/1ps

module plic_properties (
    input logic clk,
    input logic rstn,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic irq
);

    ack_single: assert property (@(posedge clk) disable iff (!rstn) ack |=> !ack)
        else $error("wishbone ack held for more than one cycle");

    // ack answers a request seen on the cycle before.
    ack_after_req: assert property (@(posedge clk) disable iff (!rstn) ack |-> $past(cyc && stb))
        else $error("wishbone ack without a preceding cyc and stb");

    irq_quiet: assert property (@(posedge clk) $rose(rstn) |-> !irq ##1 !irq)
        else $error("irq raised within two cycles of reset release");

endmodule

// slave has no irq, core has no bus side.
bind plic_wb_slave plic_properties wb_props (
    .clk  (clk),
    .rstn (rstn),
    .cyc  (wb_in.cyc),
    .stb  (wb_in.stb),
    .ack  (wb_out.ack),
    .irq  (1'b0)
);

bind plic_core plic_properties core_props (
    .clk  (clk),
    .rstn (rstn),
    .cyc  (1'b0),
    .stb  (1'b0),
    .ack  (1'b0),
    .irq  (irq)
);

/* rtl/plic_top.sv */
`timescale 1ns/1ps

module plic_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  plic_bus_pkg::wb_req_t  wb_in,
    output plic_bus_pkg::wb_rsp_t  wb_out,
    input  plic_cfg_pkg::src_vec_t src_req,
    output logic                   irq
);
    import plic_cfg_pkg::*;
    import plic_bus_pkg::*;

    reg_req_t    reg_req;
    logic [31:0] rdata;
    src_vec_t    pend_set;
    src_vec_t    complete;

    plic_wb_slave wb0 (
        .clk     (clk),
        .rstn    (rstn),
        .wb_in   (wb_in),
        .wb_out  (wb_out),
        .reg_req (reg_req),
        .rdata   (rdata)
    );

    plic_gateway gw0 (
        .clk      (clk),
        .rstn     (rstn),
        .src_req  (src_req),
        .complete (complete),
        .pend_set (pend_set)
    );

    plic_core core0 (
        .clk      (clk),
        .rstn     (rstn),
        .reg_req  (reg_req),
        .rdata    (rdata),
        .pend_set (pend_set),
        .complete (complete),
        .irq      (irq)
    );

endmodule

/* rtl/plic_core.sv */
`timescale 1ns/1ps

module plic_core (
    input  logic                   clk,
    input  logic                   rstn,
    input  plic_bus_pkg::reg_req_t reg_req,
    output logic [31:0]            rdata,
    input  plic_cfg_pkg::src_vec_t pend_set,
    output plic_cfg_pkg::src_vec_t complete,
    output logic                   irq
);
    import plic_cfg_pkg::*;

    prio_t    prio_q [num_src];
    src_vec_t pending_q;
    src_vec_t enable_q;
    prio_t    threshold_q;

    src_id_t  prio_idx;
    logic     is_prio;
    logic     is_pending;
    logic     is_enable;
    logic     is_threshold;
    logic     is_claim;
    logic     rd;
    logic     wr;
    logic     cmpl_id_ok;
    logic [31:0] rd_mux;
    src_vec_t claim_clr;
    src_vec_t complete_nxt;

    src_id_t  winner_id;
    logic     winner_valid;

    assign rd = reg_req.valid && (reg_req.op == reg_read);
    assign wr = reg_req.valid && (reg_req.op == reg_write);

    // priority block spans one word per source slot.
    assign prio_idx     = reg_req.addr[id_w+1:2];
    assign is_prio      = (reg_req.addr >> (id_w + 2)) == (prio_base >> (id_w + 2));
    assign is_pending   = reg_req.addr == pending_addr;
    assign is_enable    = reg_req.addr == enable_addr;
    assign is_threshold = reg_req.addr == threshold_addr;
    assign is_claim     = reg_req.addr == claim_addr;

    // claim read drops the winner's pending bit.
    assign claim_clr = (rd && is_claim && winner_valid) ? (src_vec_t'(1) << winner_id) : '0;

    assign cmpl_id_ok   = reg_req.wdata[31:id_w] == '0;
    assign complete_nxt = (wr && is_claim && cmpl_id_ok)
                          ? ((src_vec_t'(1) << reg_req.wdata[id_w-1:0]) & ~src_vec_t'(1))
                          : '0;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < num_src; i++)
                prio_q[i] <= '0;
            enable_q    <= '0;
            threshold_q <= '0;
        end
        else if (wr)
        begin
            if (is_prio && prio_idx != '0)
                prio_q[prio_idx] <= reg_req.wdata[prio_w-1:0];
            if (is_enable)
                enable_q <= reg_req.wdata;
            if (is_threshold)
                threshold_q <= reg_req.wdata[prio_w-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            pending_q <= '0;
            complete  <= '0;
            irq       <= 1'b0;
        end
        else
        begin
            pending_q <= (pending_q | pend_set) & ~claim_clr;
            complete  <= complete_nxt; // one cycle pulse.
            irq       <= winner_valid;
        end
    end

    always_comb
    begin
        rd_mux = '0;
        if (is_prio)
            rd_mux = 32'(prio_q[prio_idx]); // slot 0 stays zero.
        else if (is_pending)
            rd_mux = pending_q;
        else if (is_enable)
            rd_mux = enable_q;
        else if (is_threshold)
            rd_mux = 32'(threshold_q);
        else if (is_claim)
            rd_mux = 32'(winner_id);
    end

    always_ff @(posedge clk)
    begin
        if (rd)
            rdata <= rd_mux;
    end

    plic_arbiter arb0 (
        .pending      (pending_q),
        .enable       (enable_q),
        .prio         (prio_q),
        .threshold    (threshold_q),
        .winner_id    (winner_id),
        .winner_valid (winner_valid)
    );

endmodule

/* rtl/plic_arbiter.sv */
`timescale 1ns/1ps

module plic_arbiter (
    input  plic_cfg_pkg::src_vec_t pending,
    input  plic_cfg_pkg::src_vec_t enable,
    input  plic_cfg_pkg::prio_t    prio [plic_cfg_pkg::num_src],
    input  plic_cfg_pkg::prio_t    threshold,
    output plic_cfg_pkg::src_id_t  winner_id,
    output logic                   winner_valid
);
    import plic_cfg_pkg::*;

    // level 0 holds the leaves, the last level the root.
    prio_t   node_p  [$clog2(num_src)+1][num_src];
    src_id_t node_id [$clog2(num_src)+1][num_src];

    always_comb
    begin
        for (int l = 0; l <= $clog2(num_src); l++)
        begin
            for (int n = 0; n < num_src; n++)
            begin
                node_p[l][n]  = '0;
                node_id[l][n] = '0;
            end
        end

        for (int n = 0; n < num_src; n++)
        begin
            node_p[0][n]  = (pending[n] && enable[n]) ? prio[n] : '0;
            node_id[0][n] = src_id_t'(n);
        end

        for (int l = 1; l <= $clog2(num_src); l++)
        begin
            for (int n = 0; n < (num_src >> l); n++)
            begin
                // left child has the lower id, keeps ties.
                if (node_p[l-1][2*n] >= node_p[l-1][2*n+1])
                begin
                    node_p[l][n]  = node_p[l-1][2*n];
                    node_id[l][n] = node_id[l-1][2*n];
                end
                else
                begin
                    node_p[l][n]  = node_p[l-1][2*n+1];
                    node_id[l][n] = node_id[l-1][2*n+1];
                end
            end
        end
    end

    assign winner_valid = node_p[$clog2(num_src)][0] > threshold;
    assign winner_id    = winner_valid ? node_id[$clog2(num_src)][0] : '0;

endmodule

/* rtl/plic_gateway.sv */
`timescale 1ns/1ps

module plic_gateway (
    input  logic                   clk,
    input  logic                   rstn,
    input  plic_cfg_pkg::src_vec_t src_req,
    input  plic_cfg_pkg::src_vec_t complete,
    output plic_cfg_pkg::src_vec_t pend_set
);
    import plic_cfg_pkg::*;

    src_vec_t in_flight;
    src_vec_t live_mask;
    src_vec_t fire;

    assign live_mask = {{(num_src-1){1'b1}}, 1'b0}; // slot 0 never forwards.

    // level high and nothing outstanding for that source.
    assign fire = src_req & ~in_flight & live_mask;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            in_flight <= '0;
            pend_set  <= '0;
        end
        else
        begin
            // held until the handler writes the id back to claim.
            in_flight <= ((in_flight & ~complete) | fire) & live_mask;
            pend_set  <= fire;
        end
    end

endmodule

/* rtl/plic_wb_slave.sv */
`timescale 1ns/1ps

module plic_wb_slave (
    input  logic                   clk,
    input  logic                   rstn,
    input  plic_bus_pkg::wb_req_t  wb_in,
    output plic_bus_pkg::wb_rsp_t  wb_out,
    output plic_bus_pkg::reg_req_t reg_req,
    input  logic [31:0]            rdata
);
    import plic_cfg_pkg::*;

    typedef enum logic
    {
        wb_idle,
        wb_ack
    } wb_state_e;

    wb_state_e state;
    wb_state_e state_nxt;
    logic      access;

    // new access only from idle, so ack never repeats.
    assign access = (state == wb_idle) && wb_in.cyc && wb_in.stb;

    always_comb
    begin
        reg_req.valid = access;
        reg_req.op    = wb_in.we ? reg_write : reg_read;
        reg_req.addr  = wb_in.adr;
        reg_req.wdata = wb_in.dat;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            wb_idle:
            begin
                if (access)
                    state_nxt = wb_ack;
            end
            wb_ack:  state_nxt = wb_idle; // single cycle ack.
            default: state_nxt = wb_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            state <= wb_idle;
        else
            state <= state_nxt;
    end

    // core data is already registered, lines up with ack.
    assign wb_out.ack = (state == wb_ack);
    assign wb_out.dat = (state == wb_ack) ? rdata : 32'h0;

endmodule

/* rtl/plic_bus_pkg.sv */
package plic_bus_pkg;

    // master side of a wishbone classic cycle.
    typedef struct packed
    {
        logic                              cyc;
        logic                              stb;
        logic                              we;
        logic [plic_cfg_pkg::addr_w-1:0]   adr;
        logic [31:0]                       dat;
    } wb_req_t;

    typedef struct packed
    {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // one register operation, slave to core.
    typedef struct packed
    {
        logic                              valid;
        plic_cfg_pkg::reg_op_e             op;
        logic [plic_cfg_pkg::addr_w-1:0]   addr;
        logic [31:0]                       wdata;
    } reg_req_t;

endpackage

/* rtl/plic_cfg_pkg.sv */
package plic_cfg_pkg;

    // slot 0 is the reserved id.
    localparam int num_src = 32;
    localparam int prio_w  = 3;
    localparam int id_w    = 5;
    localparam int addr_w  = 24;

    localparam logic [addr_w-1:0] prio_base      = 24'h000000; // source n at 4*n.
    localparam logic [addr_w-1:0] pending_addr   = 24'h001000;
    localparam logic [addr_w-1:0] enable_addr    = 24'h002000;
    localparam logic [addr_w-1:0] threshold_addr = 24'h200000;
    localparam logic [addr_w-1:0] claim_addr     = 24'h200004;

    typedef logic [num_src-1:0] src_vec_t;
    typedef logic [prio_w-1:0]  prio_t;
    typedef logic [id_w-1:0]    src_id_t;

    typedef enum logic
    {
        reg_read,
        reg_write
    } reg_op_e;

endpackage
